//--- common/enc_defs.svh
`ifndef ENC_DEFS_SVH
`define ENC_DEFS_SVH

// ----------------------------------------
// symbol widths
// ----------------------------------------

`define ENC_DATA_W    8     // unencoded byte
`define ENC_CODE_W    10    // abcdei + fghj

// ----------------------------------------
// running disparity
// ----------------------------------------

// value after reset, 0 is negative
`define ENC_RD_RESET  1'b0

`endif

//--- common/enc_pkg.sv
`default_nettype none

`include "enc_defs.svh"

package enc_pkg;

    // ----------------------------------------
    // plain vectors
    // ----------------------------------------

    typedef logic [`ENC_DATA_W-1:0] byte_t;    // HGFEDCBA
    typedef logic [4:0]             sub5_t;    // EDCBA
    typedef logic [2:0]             sub3_t;    // HGF
    typedef logic [5:0]             code6_t;   // abcdei, a on top
    typedef logic [3:0]             code4_t;   // fghj, f on top
    typedef logic [`ENC_CODE_W-1:0] code10_t;  // abcdei in [9:4], fghj in [3:0]

    // running disparity sign
    typedef enum logic {
        RD_NEG = 1'b0,
        RD_POS = 1'b1
    } disp_t;

    // ----------------------------------------
    // bundles
    // ----------------------------------------

    typedef struct packed {
        byte_t data;
        logic  k;       // control request
    } enc_in_t;

    typedef struct packed {
        code10_t code;
        disp_t   rd;     // disparity after this group
        logic    k_err;  // k set on a byte with no K code
    } enc_out_t;

endpackage

`default_nettype wire

//--- src/encode_5b6b.sv
`default_nettype none

module encode_5b6b import enc_pkg::*; (
    input  wire sub5_t  sub,     // EDCBA
    input  wire         k,
    input  wire disp_t  rd_in,   // disparity before the group
    output code6_t      code,    // abcdei
    output disp_t       rd_out   // disparity after abcdei
);

    // rd- form in [11:6], rd+ form in [5:0]
    logic [11:0] forms;
    disp_t       rd_flip;

    // ----------------------------------------
    // 5b/6b table
    // ----------------------------------------

    always_comb begin
        case (sub)
            5'd0:  forms = {6'b100111, 6'b011000};
            5'd1:  forms = {6'b011101, 6'b100010};
            5'd2:  forms = {6'b101101, 6'b010010};
            5'd3:  forms = {6'b110001, 6'b110001};
            5'd4:  forms = {6'b110101, 6'b001010};
            5'd5:  forms = {6'b101001, 6'b101001};
            5'd6:  forms = {6'b011001, 6'b011001};
            // balanced but still has two forms
            5'd7:  forms = {6'b111000, 6'b000111};
            5'd8:  forms = {6'b111001, 6'b000110};
            5'd9:  forms = {6'b100101, 6'b100101};
            5'd10: forms = {6'b010101, 6'b010101};
            5'd11: forms = {6'b110100, 6'b110100};
            5'd12: forms = {6'b001101, 6'b001101};
            5'd13: forms = {6'b101100, 6'b101100};
            5'd14: forms = {6'b011100, 6'b011100};
            5'd15: forms = {6'b010111, 6'b101000};
            5'd16: forms = {6'b011011, 6'b100100};
            5'd17: forms = {6'b100011, 6'b100011};
            5'd18: forms = {6'b010011, 6'b010011};
            5'd19: forms = {6'b110010, 6'b110010};
            5'd20: forms = {6'b001011, 6'b001011};
            5'd21: forms = {6'b101010, 6'b101010};
            5'd22: forms = {6'b011010, 6'b011010};
            5'd23: forms = {6'b111010, 6'b000101};
            5'd24: forms = {6'b110011, 6'b001100};
            5'd25: forms = {6'b100110, 6'b100110};
            5'd26: forms = {6'b010110, 6'b010110};
            5'd27: forms = {6'b110110, 6'b001001};
            5'd28: forms = {6'b001110, 6'b001110};
            5'd29: forms = {6'b101110, 6'b010001};
            5'd30: forms = {6'b011110, 6'b100001};
            5'd31: forms = {6'b101011, 6'b010100};
        endcase

        // K28 swaps the balanced data code for the comma pair
        if (k && sub == 5'd28) begin
            forms = {6'b001111, 6'b110000};
        end
    end

    // ----------------------------------------
    // form select and disparity
    // ----------------------------------------

    assign code = (rd_in == RD_POS) ? forms[5:0] : forms[11:6];

    assign rd_flip = (rd_in == RD_NEG) ? RD_POS : RD_NEG;

    // three ones is neutral, anything else is +/-2
    assign rd_out = ($countones(code) == 3) ? rd_in : rd_flip;

endmodule

`default_nettype wire

//--- src/encode_3b4b.sv
`default_nettype none

module encode_3b4b import enc_pkg::*; (
    input  wire sub3_t   sub,     // HGF
    input  wire          k,
    input  wire code6_t  code6,   // abcdei from the first stage
    input  wire disp_t   rd_in,   // disparity after abcdei
    output code4_t       code,    // fghj
    output disp_t        rd_out   // disparity after the whole group
);

    // rd- form in [7:4], rd+ form in [3:0]
    logic [7:0] forms;
    logic       use_a7;
    disp_t      rd_flip;

    // ----------------------------------------
    // A7 select
    // ----------------------------------------

    // P7 would leave a run of five equal bits across the e/i boundary
    assign use_a7 = (rd_in == RD_NEG && code6[1:0] == 2'b11) ||
                    (rd_in == RD_POS && code6[1:0] == 2'b00);

    // ----------------------------------------
    // 3b/4b tables
    // ----------------------------------------

    always_comb begin
        if (k) begin
            case (sub)
                3'd0: forms = {4'b1011, 4'b0100};
                3'd1: forms = {4'b0110, 4'b1001};
                3'd2: forms = {4'b1010, 4'b0101};
                3'd3: forms = {4'b1100, 4'b0011};
                3'd4: forms = {4'b1101, 4'b0010};
                3'd5: forms = {4'b0101, 4'b1010};
                3'd6: forms = {4'b1001, 4'b0110};
                3'd7: forms = {4'b0111, 4'b1000};  // always the alternate
            endcase
        end else begin
            case (sub)
                3'd0: forms = {4'b1011, 4'b0100};
                3'd1: forms = {4'b1001, 4'b1001};
                3'd2: forms = {4'b0101, 4'b0101};
                3'd3: forms = {4'b1100, 4'b0011};
                3'd4: forms = {4'b1101, 4'b0010};
                3'd5: forms = {4'b1010, 4'b1010};
                3'd6: forms = {4'b0110, 4'b0110};
                3'd7: begin
                    if (use_a7) begin
                        forms = {4'b0111, 4'b1000};  // D.x.A7
                    end else begin
                        forms = {4'b1110, 4'b0001};  // D.x.P7
                    end
                end
            endcase
        end
    end

    // ----------------------------------------
    // form select and disparity
    // ----------------------------------------

    assign code = (rd_in == RD_POS) ? forms[3:0] : forms[7:4];

    assign rd_flip = (rd_in == RD_NEG) ? RD_POS : RD_NEG;

    // two ones is neutral
    assign rd_out = ($countones(code) == 2) ? rd_in : rd_flip;

endmodule

`default_nettype wire

//--- src/enc8b10b.sv
`default_nettype none

`include "enc_defs.svh"

module enc8b10b import enc_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           in_valid,
    input  wire enc_in_t  in_sym,
    input  wire           rd_load,      // seed the disparity this cycle
    input  wire disp_t    rd_load_val,
    output logic          out_valid,
    output enc_out_t      out
);

    disp_t   rd_q;        // running disparity
    disp_t   rd_start;
    disp_t   rd_mid;      // after abcdei
    disp_t   rd_final;    // after fghj
    code6_t  code6;
    code4_t  code4;
    logic    k_ok;
    logic    k_err;

    // a load in the same cycle applies to the symbol already
    assign rd_start = rd_load ? rd_load_val : rd_q;

    // ----------------------------------------
    // table stages
    // ----------------------------------------

    encode_5b6b u_5b6b (
        .sub    (in_sym.data[4:0]),
        .k      (in_sym.k),
        .rd_in  (rd_start),
        .code   (code6),
        .rd_out (rd_mid)
    );

    encode_3b4b u_3b4b (
        .sub    (in_sym.data[7:5]),
        .k      (in_sym.k),
        .code6  (code6),
        .rd_in  (rd_mid),
        .code   (code4),
        .rd_out (rd_final)
    );

    // ----------------------------------------
    // control symbol check
    // ----------------------------------------

    // K28.0-K28.7, and K23/K27/K29/K30 only with .7
    always_comb begin
        case (in_sym.data[4:0])
            5'd28:                      k_ok = 1'b1;
            5'd23, 5'd27, 5'd29, 5'd30: k_ok = (in_sym.data[7:5] == 3'd7);
            default:                    k_ok = 1'b0;
        endcase
    end

    assign k_err = in_sym.k && !k_ok;

    // ----------------------------------------
    // disparity and output registers
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= disp_t'(`ENC_RD_RESET);
        end else if (in_valid) begin
            rd_q <= rd_final;
        end else if (rd_load) begin
            rd_q <= rd_load_val;     // idle seed
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out.code  <= {code6, code4};
                out.rd    <= rd_final;
                out.k_err <= k_err;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/enc_ref.svh
`ifndef ENC_REF_SVH
`define ENC_REF_SVH

// ----------------------------------------
// standard tables, rd- column
// ----------------------------------------

// abcdei of D.x for running disparity negative
localparam code6_t DATA6_NEG [0:31] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001,   // 0-3
    6'b110101, 6'b101001, 6'b011001, 6'b111000,   // 4-7
    6'b111001, 6'b100101, 6'b010101, 6'b110100,   // 8-11
    6'b001101, 6'b101100, 6'b011100, 6'b010111,   // 12-15
    6'b011011, 6'b100011, 6'b010011, 6'b110010,   // 16-19
    6'b001011, 6'b101010, 6'b011010, 6'b111010,   // 20-23
    6'b110011, 6'b100110, 6'b010110, 6'b110110,   // 24-27
    6'b001110, 6'b101110, 6'b011110, 6'b101011    // 28-31
};

localparam code6_t K28_NEG = 6'b001111;

// fghj of D.x.y, entry 7 is the primary P7
localparam code4_t DATA4_NEG [0:7] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100,
    4'b1101, 4'b1010, 4'b0110, 4'b1110
};

localparam code4_t ALT7_NEG = 4'b0111;

localparam code4_t CTRL4_NEG [0:7] = '{
    4'b1011, 4'b0110, 4'b1010, 4'b1100,
    4'b1101, 4'b0101, 4'b1001, 4'b0111
};

// K28.0-K28.7, K23.7, K27.7, K29.7, K30.7
localparam byte_t K_CODES [0:11] = '{
    8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC,
    8'hF7, 8'hFB, 8'hFD, 8'hFE
};

// ----------------------------------------
// helpers
// ----------------------------------------

function automatic int count_ones(input logic [9:0] v);
    int n;
    n = 0;
    for (int b = 0; b < 10; b++) begin
        n = n + int'(v[b]);
    end
    return n;
endfunction

// sign follows the weight of the group, neutral keeps it
function automatic disp_t rd_after(input int ones, input int width, input disp_t rd);
    if (2 * ones == width) begin
        return rd;
    end
    return (2 * ones > width) ? RD_POS : RD_NEG;
endfunction

function automatic bit is_k_code(input byte_t b);
    bit hit;
    hit = 1'b0;
    for (int j = 0; j < 12; j++) begin
        if (K_CODES[j] == b) begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

function automatic code6_t lookup_6b(input sub5_t x, input logic k, input disp_t rd);
    code6_t neg;
    bit     flip;
    neg = (k && x == 5'd28) ? K28_NEG : DATA6_NEG[x];
    // rd+ column is the complement for unbalanced codes and D.7
    flip = (count_ones({4'b0, neg}) != 3) || (x == 5'd7);
    return (rd == RD_POS && flip) ? ~neg : neg;
endfunction

function automatic code4_t lookup_4b(input sub3_t y, input sub5_t x, input logic k,
                                     input disp_t rd);
    code4_t neg;
    bit     flip;
    if (k) begin
        neg  = CTRL4_NEG[y];
        flip = 1'b1;                   // every K column pair is complementary
    end else begin
        neg = DATA4_NEG[y];
        if (y == 3'd7 && ((rd == RD_NEG && x inside {5'd17, 5'd18, 5'd20}) ||
                          (rd == RD_POS && x inside {5'd11, 5'd13, 5'd14}))) begin
            neg = ALT7_NEG;
        end
        flip = (count_ones({6'b0, neg}) != 2) || (y == 3'd3);
    end
    return (rd == RD_POS && flip) ? ~neg : neg;
endfunction

// ----------------------------------------
// expected output for one symbol
// ----------------------------------------

function automatic enc_out_t enc_ref(input enc_in_t sym, input disp_t rd);
    enc_out_t res;
    sub5_t    x;
    sub3_t    y;
    code6_t   c6;
    code4_t   c4;
    disp_t    mid;
    x   = sym.data[4:0];
    y   = sym.data[7:5];
    c6  = lookup_6b(x, sym.k, rd);
    mid = rd_after(count_ones({4'b0, c6}), 6, rd);
    c4  = lookup_4b(y, x, sym.k, mid);
    res.code  = {c6, c4};
    res.rd    = rd_after(count_ones({6'b0, c4}), 4, mid);
    res.k_err = sym.k && !is_k_code(sym.data);
    return res;
endfunction

`endif

//--- bench/tb_enc8b10b.sv
`default_nettype none

module tb_enc8b10b import enc_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF   = 10;
    localparam int DRIVE_SKEW = 2;
    localparam int DRAIN_MAX  = 50;     // cycles for the last outputs

    typedef struct packed {
        logic     valid;
        enc_out_t exp;
    } cyc_t;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    enc_in_t  in_sym;
    logic     rd_load;
    disp_t    rd_load_val;
    logic     out_valid;
    enc_out_t out;

    cyc_t     cyc_q[$];          // one entry per driven cycle
    disp_t    model_rd;          // disparity as the model tracks it
    int       driven = 0;
    int       checked = 0;

`include "enc_ref.svh"

    enc8b10b dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_sym      (in_sym),
        .rd_load     (rd_load),
        .rd_load_val (rd_load_val),
        .out_valid   (out_valid),
        .out         (out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_code(input code10_t got, input code10_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch out.code: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_rd(input disp_t got, input disp_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch out.rd: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    task automatic drive_sym(input enc_in_t sym, input logic load, input disp_t load_val);
        disp_t    start;
        cyc_t     cyc;
        @(posedge clk);
        #DRIVE_SKEW;
        start       = load ? load_val : model_rd;
        cyc.valid   = 1'b1;
        cyc.exp     = enc_ref(sym, start);
        model_rd    = cyc.exp.rd;
        in_valid    = 1'b1;
        in_sym      = sym;
        rd_load     = load;
        rd_load_val = load_val;
        cyc_q.push_back(cyc);
        driven++;
    endtask

    task automatic drive_idle(input logic load, input disp_t load_val);
        cyc_t cyc;
        @(posedge clk);
        #DRIVE_SKEW;
        in_valid    = 1'b0;
        rd_load     = load;
        rd_load_val = load_val;
        if (load) begin
            model_rd = load_val;
        end
        cyc.valid = 1'b0;
        cyc.exp   = '0;
        cyc_q.push_back(cyc);
        driven++;
    endtask

    task automatic all_data_pass(input disp_t start);
        enc_in_t sym;
        for (int i = 0; i < 256; i++) begin
            sym.data = byte_t'(i);
            sym.k    = 1'b0;
            drive_sym(sym, i == 0, start);   // seed on the first byte only
        end
    endtask

    task automatic control_pass(input disp_t start);
        enc_in_t sym;
        for (int j = 0; j < 12; j++) begin
            sym.data = K_CODES[j];
            sym.k    = 1'b1;
            drive_sym(sym, 1'b1, start);
        end
    endtask

    // every byte with k set that has no K code
    task automatic bad_control_pass();
        enc_in_t sym;
        for (int i = 0; i < 256; i++) begin
            sym.data = byte_t'(i);
            sym.k    = 1'b1;
            if (!is_k_code(sym.data)) begin
                drive_sym(sym, 1'b0, RD_NEG);
            end
        end
    endtask

    task automatic random_stream(input int count, input int max_gap, input logic loads);
        logic [31:0] r;
        enc_in_t     sym;
        int          gap;
        for (int i = 0; i < count; i++) begin
            r        = $urandom();
            sym.data = r[7:0];
            sym.k    = 1'b0;
            if (r[10:8] == 3'd0) begin
                sym.data = K_CODES[int'(r[15:12]) % 12];
                sym.k    = 1'b1;
            end
            drive_sym(sym, loads && r[16], disp_t'(r[17]));
            gap = (max_gap > 0) ? int'(r[23:20]) % (max_gap + 1) : 0;
            repeat (gap) drive_idle(1'b0, RD_NEG);
        end
    endtask

    // ----------------------------------------
    // compare process
    // ----------------------------------------

    initial begin : compare
        cyc_t     cur;
        enc_out_t last;
        last = '0;                       // reset value of out
        forever begin
            @(posedge clk);
            if (cyc_q.size() > 0) begin
                cur = cyc_q.pop_front();
                @(negedge clk);
                check_flag("out_valid", out_valid, cur.valid);
                if (cur.valid) begin
                    last = cur.exp;
                end
                // idle cycles hold the previous group
                check_code(out.code, last.code);
                check_rd(out.rd, last.rd);
                check_flag("out.k_err", out.k_err, last.k_err);
                checked++;
            end
        end
    end

    initial begin : stimulus
        int wait_cycles;
        void'($urandom(32'h6fc9));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_sym      = '0;
        rd_load     = 1'b0;
        rd_load_val = RD_NEG;
        model_rd    = RD_NEG;
        repeat (5) @(posedge clk);
        #DRIVE_SKEW;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_code(out.code, '0);
        check_rd(out.rd, RD_NEG);
        check_flag("out.k_err", out.k_err, 1'b0);

        all_data_pass(RD_NEG);
        all_data_pass(RD_POS);
        control_pass(RD_NEG);
        control_pass(RD_POS);
        random_stream(2000, 0, 1'b0);
        bad_control_pass();
        random_stream(400, 3, 1'b0);
        drive_idle(1'b1, RD_POS);        // seed while idle
        random_stream(20, 0, 1'b0);
        random_stream(300, 1, 1'b1);
        drive_idle(1'b0, RD_NEG);

        wait_cycles = 0;
        while (checked < driven) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > DRAIN_MAX) begin
                fail_run("timed out waiting for the last outputs to be checked");
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- enc8b10b.f
+incdir+common
+incdir+bench
common/enc_pkg.sv
src/encode_5b6b.sv
src/encode_3b4b.sv
src/enc8b10b.sv
bench/tb_enc8b10b.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module tb_enc8b10b \
    -f enc8b10b.f -o tb_enc8b10b

sim_out=$(./obj_dir/tb_enc8b10b) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
